// ==== rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register width, one word.
`define XLEN 32

// word index width of each external memory.
`define MEM_AW 10

// architectural register count, x0 included.
`define NUM_REGS 32

// pc byte increment per instruction.
`define PC_STEP 4

`endif

// ==== rv_pkg.sv ====
package rv_pkg;

    // base opcodes of the supported subset.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8
    } alu_op_e;

    // alu operand a source.
    typedef enum logic [1:0] {
        SRC_A_PC   = 2'd0,
        SRC_A_ZERO = 2'd1,
        SRC_A_RS1  = 2'd2
    } src_a_e;

    // one instruction word, five field layouts.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_e    opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_e    opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            opcode_e     opcode;
        } u;
    } instr_u;

endpackage

// ==== rv_alu.sv ====
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  rv_pkg::alu_op_e  op,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // rv32 shifts use five bits only.

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // signed compare, result is 0 or 1.
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = $unsigned($signed(a) >>> shamt);
            default: result = a + b;
        endcase
    end

    // beq uses sub, equal operands give zero.
    assign zero = (result == '0);

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/10ps

module rv_decoder (
    input  rv_pkg::instr_u  instr,
    output logic            reg_we,
    output logic            mem_we,
    output logic            mem_to_reg,
    output logic            alu_src_b_imm,
    output rv_pkg::src_a_e  src_a,
    output rv_pkg::alu_op_e alu_op,
    output logic            branch
);

    import rv_pkg::*;

    logic    alt_fn;
    alu_op_e funct_op;

    // bit 30 picks sub/sra; for immediates only on shifts.
    assign alt_fn = instr.r.funct7[5] &
                    ((instr.r.opcode == OPC_OP) || (instr.r.funct3 == 3'b101));

    always_comb begin
        case (instr.r.funct3)
            3'b000:  funct_op = alt_fn ? ALU_SUB : ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = alt_fn ? ALU_SRA : ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            3'b111:  funct_op = ALU_AND;
            default: funct_op = ALU_ADD; // sltu not in the subset.
        endcase
    end

    always_comb begin
        reg_we        = 1'b0; // unknown opcode is a no-op.
        mem_we        = 1'b0;
        mem_to_reg    = 1'b0;
        alu_src_b_imm = 1'b0;
        src_a         = SRC_A_RS1;
        alu_op        = ALU_ADD;
        branch        = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                reg_we = 1'b1;
                alu_op = funct_op;
            end
            OPC_OP_IMM: begin
                reg_we        = 1'b1;
                alu_src_b_imm = 1'b1;
                alu_op        = funct_op;
            end
            OPC_LOAD: begin
                reg_we        = 1'b1;
                mem_to_reg    = 1'b1;
                alu_src_b_imm = 1'b1; // rs1 + offset.
            end
            OPC_STORE: begin
                mem_we        = 1'b1;
                alu_src_b_imm = 1'b1;
            end
            OPC_BRANCH: begin
                branch = 1'b1;
                alu_op = ALU_SUB; // compare through zero flag.
            end
            OPC_LUI: begin
                reg_we        = 1'b1;
                alu_src_b_imm = 1'b1;
                src_a         = SRC_A_ZERO;
            end
            OPC_AUIPC: begin
                reg_we        = 1'b1;
                alu_src_b_imm = 1'b1;
                src_a         = SRC_A_PC;
            end
            default: ;
        endcase
    end

endmodule

// ==== rv_imm_gen.sv ====
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_imm_gen (
    input  rv_pkg::instr_u   instr,
    output logic [`XLEN-1:0] imm
);

    import rv_pkg::*;

    always_comb begin
        case (instr.r.opcode)
            OPC_OP_IMM, OPC_LOAD: begin
                imm = {{(`XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            OPC_STORE: begin
                imm = {{(`XLEN-12){instr.s.imm_11_5[6]}},
                       instr.s.imm_11_5, instr.s.imm_4_0};
            end
            OPC_BRANCH: begin
                // bit 0 always clear, halfword aligned.
                imm = {{(`XLEN-13){instr.b.imm_12}}, instr.b.imm_12,
                       instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr.u.imm_31_12, 12'h000}; // upper 20 bits.
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_regfile (
    input  logic             CLK,
    input  logic             RESET_N,
    input  logic [4:0]       rs1_idx,
    input  logic [4:0]       rs2_idx,
    input  logic [4:0]       rd_idx,
    input  logic [`XLEN-1:0] rd_data,
    input  logic             we,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_idx != 5'd0)) begin
            regs[rd_idx] <= rd_data; // x0 never written.
        end
    end

    // x0 reads as zero regardless of array contents.
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// ==== rv_core.sv ====
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core (
    input  logic              CLK,
    input  logic              RESET_N,
    output logic [`MEM_AW-1:0] rom_addr,
    input  logic [`XLEN-1:0]  rom_data,
    output logic [`MEM_AW-1:0] ram_addr,
    input  logic [`XLEN-1:0]  ram_rdata,
    output logic [`XLEN-1:0]  ram_wdata,
    output logic              ram_we
);

    import rv_pkg::*;

    localparam int BYTE_OFS = $clog2(`PC_STEP); // byte to word index shift.

    instr_u           instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;
    logic             reg_we;
    logic             mem_we;
    logic             mem_to_reg;
    logic             alu_src_b_imm;
    src_a_e           src_a;
    alu_op_e          alu_op;
    logic             branch;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_zero;
    logic [`XLEN-1:0] wb_data;

    assign instr = rom_data;

    rv_decoder i_decoder (
        .instr         (instr),
        .reg_we        (reg_we),
        .mem_we        (mem_we),
        .mem_to_reg    (mem_to_reg),
        .alu_src_b_imm (alu_src_b_imm),
        .src_a         (src_a),
        .alu_op        (alu_op),
        .branch        (branch)
    );

    rv_imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    rv_regfile i_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_idx  (instr.r.rs1),
        .rs2_idx  (instr.r.rs2),
        .rd_idx   (instr.r.rd),
        .rd_data  (wb_data),
        .we       (reg_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // operand a: pc for auipc, zero for lui.
    always_comb begin
        case (src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b = alu_src_b_imm ? imm : rs2_data;

    rv_alu i_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign wb_data = mem_to_reg ? ram_rdata : alu_result;

    // no store while held in reset.
    assign ram_we    = mem_we & RESET_N;
    assign ram_wdata = rs2_data;
    assign ram_addr  = alu_result[`MEM_AW+BYTE_OFS-1:BYTE_OFS];

    // taken beq jumps pc relative.
    assign pc_next = (branch && alu_zero) ? (pc + imm) : (pc + `XLEN'(`PC_STEP));

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign rom_addr = pc[`MEM_AW+BYTE_OFS-1:BYTE_OFS];

endmodule

// ==== rv_core_checker.sv ====
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core_checker (
    input logic               CLK,
    input logic               RESET_N,
    input logic [`MEM_AW-1:0] rom_addr,
    input logic [`XLEN-1:0]   rom_data,
    input logic               ram_we
);

    import rv_pkg::*;

    logic [6:0] opcode;

    assign opcode = rom_data[6:0];

    // writes are gated while reset holds the core.
    a_no_we_in_reset: assert property (@(posedge CLK) !RESET_N |-> !ram_we)
        else $error("ram_we high while RESET_N is low");

    a_rom_addr_known: assert property (@(posedge CLK) disable iff (!RESET_N)
        !$isunknown(rom_addr))
        else $error("rom_addr unknown after reset");

    a_we_only_on_store: assert property (@(posedge CLK) disable iff (!RESET_N)
        ram_we |-> (opcode == OPC_STORE))
        else $error("ram_we high on an opcode other than STORE");

    // anything but a branch steps to the next word.
    a_seq_fetch: assert property (@(posedge CLK) disable iff (!RESET_N)
        (opcode != OPC_BRANCH) |=> (rom_addr == $past(rom_addr) + 1'b1))
        else $error("rom_addr did not advance by one after a non-branch");

endmodule

bind rv_core rv_core_checker i_checker (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .ram_we   (ram_we)
);

// ==== rv_core_tb.sv ====
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core_tb;

    import rv_pkg::*;

    localparam int PROG_LEN   = 300;
    localparam int MAX_CYCLES = 2000;
    localparam int MEM_WORDS  = 2 ** `MEM_AW;
    localparam int T_RESET  = 0;
    localparam int T_FETCH  = 1;
    localparam int T_BRANCH = 2;
    localparam int T_STORE  = 3;
    localparam int T_LOAD   = 4;
    localparam int T_MEM    = 5;
    localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0.

    logic               CLK;
    logic               RESET_N;
    logic [`MEM_AW-1:0] rom_addr;
    logic [`XLEN-1:0]   rom_data;
    logic [`MEM_AW-1:0] ram_addr;
    logic [`XLEN-1:0]   ram_rdata;
    logic [`XLEN-1:0]   ram_wdata;
    logic               ram_we;

    logic [`XLEN-1:0] rom [MEM_WORDS];
    logic [`XLEN-1:0] ram [MEM_WORDS];
    logic [`XLEN-1:0] ref_mem [MEM_WORDS]; // reference model copies.
    logic [`XLEN-1:0] ref_reg [`NUM_REGS];
    logic [`XLEN-1:0] ref_pc;
    logic             prev_branch;
    logic             prev_load;
    logic [4:0]       load_rd;
    integer           seed;
    int               errs [6];
    int               tests_run;
    int               tests_failed;
    int               n_branch;
    int               n_store;
    int               n_load;

    rv_core i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // both memories answer in the same cycle.
    assign rom_data  = rom[rom_addr];
    assign ram_rdata = ram[ram_addr];

    always @(posedge CLK) begin
        if (ram_we) ram[ram_addr] <= ram_wdata;
    end

    task automatic report_mismatch(input int test, input string sig,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("error: %s is %h, expected %h (model pc %h)", sig, got, exp, ref_pc);
        errs[test]++;
    endtask

    task automatic finish_test(input int test, input string name);
        tests_run++;
        if (errs[test] != 0) tests_failed++;
        $display("%s: %s, %0d errors", name, (errs[test] == 0) ? "passed" : "failed", errs[test]);
    endtask

    // reference alu straight from the rv32i definitions.
    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] ofs, input logic [4:0] src);
        return {ofs[11:5], src, 5'd0, 3'b010, ofs[4:0], OPC_STORE}; // sw src, ofs(x0).
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] ofs);
        return {ofs[12], ofs[10:5], rs2, rs1, 3'b000, ofs[4:1], ofs[11], OPC_BRANCH};
    endfunction

    task automatic gen_program();
        int          idx;
        int          kind;
        logic [31:0] r;
        logic [31:0] u;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [12:0] boff;
        rom[0] = NOP; // nothing stored in the first cycle.
        idx = 1;
        while (idx < PROG_LEN) begin
            kind = $unsigned($random(seed)) % 6;
            r    = $random(seed);
            u    = $random(seed);
            f3   = r[17:15];
            off  = {4'd0, r[25:20], 2'b00};
            boff = 13'(((u % 32'd3) + 32'd1) * 32'd4); // one to three words forward.
            case (kind)
                0: begin
                    if (f3 == 3'b011) f3 = 3'b000;
                    rom[idx] = {1'b0, r[18] && (f3 == 3'b000 || f3 == 3'b101), 5'd0,
                                r[14:10], r[9:5], f3, r[4:0], OPC_OP};
                end
                1: begin
                    if (f3 inside {3'b001, 3'b011, 3'b101}) f3 = 3'b000; // no shifts.
                    rom[idx] = {u[31:20], r[9:5], f3, r[4:0], OPC_OP_IMM};
                end
                2: rom[idx] = {off, 5'd0, 3'b010, r[4:0], OPC_LOAD};
                3: rom[idx] = store_word(off, r[14:10]);
                4: rom[idx] = beq_word(r[9:5], r[18] ? r[9:5] : r[14:10], boff);
                default: rom[idx] = {u[31:12], r[4:0], r[18] ? OPC_LUI : OPC_AUIPC};
            endcase
            if (kind != 3 && kind != 4) begin
                rom[idx+1] = store_word({4'd0, u[5:0], 2'b00}, r[4:0]); // expose rd.
                idx += 2;
            end else begin
                idx += 1;
            end
        end
        for (int i = 0; i < 3; i++) begin
            rom[idx+i] = NOP; // landing pad for late branches.
        end
        rom[idx+3] = beq_word(5'd0, 5'd0, 13'd0);
    endtask

    task automatic step_model(output logic at_end);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [31:0] imm_i;
        logic        wb;
        logic        exp_we;
        int          test;
        w       = rom[ref_pc[`MEM_AW+1:2]];
        a       = ref_reg[w[19:15]];
        b       = ref_reg[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        res     = '0;
        wb      = 1'b0;
        exp_we  = 1'b0;
        at_end  = 1'b0;
        next_pc = ref_pc + 32'd4;
        test    = prev_branch ? T_BRANCH : T_FETCH;
        if (rom_addr !== ref_pc[`MEM_AW+1:2])
            report_mismatch(test, "rom_addr", 32'(rom_addr), 32'(ref_pc[`MEM_AW+1:2]));
        case (w[6:0])
            OPC_OP, OPC_OP_IMM: begin
                res = (w[6:0] == OPC_OP) ? isa_alu(w[14:12], w[30], a, b)
                                         : isa_alu(w[14:12], 1'b0, a, imm_i);
                wb  = 1'b1;
            end
            OPC_LOAD: begin
                addr = a + imm_i;
                res  = ref_mem[addr[`MEM_AW+1:2]];
                wb   = 1'b1;
                n_load++;
                if (ram_addr !== addr[`MEM_AW+1:2])
                    report_mismatch(T_LOAD, "ram_addr", 32'(ram_addr), 32'(addr[`MEM_AW+1:2]));
            end
            OPC_STORE: begin
                addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};
                exp_we = 1'b1;
                test   = (prev_load && w[24:20] == load_rd) ? T_LOAD : T_STORE;
                n_store++;
                if (ram_addr !== addr[`MEM_AW+1:2])
                    report_mismatch(T_STORE, "ram_addr", 32'(ram_addr), 32'(addr[`MEM_AW+1:2]));
                if (ram_wdata !== b) report_mismatch(test, "ram_wdata", ram_wdata, b);
                ref_mem[addr[`MEM_AW+1:2]] = b;
            end
            OPC_BRANCH: begin
                n_branch++;
                if (a == b) next_pc = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                at_end = (w == 32'h0000_0063);
            end
            OPC_LUI, OPC_AUIPC: begin
                res = {w[31:12], 12'h000} + ((w[6:0] == OPC_AUIPC) ? ref_pc : 32'd0);
                wb  = 1'b1;
            end
            default: ;
        endcase
        if (ram_we !== exp_we) report_mismatch(T_STORE, "ram_we", 32'(ram_we), 32'(exp_we));
        if (wb && w[11:7] != 5'd0) ref_reg[w[11:7]] = res;
        prev_branch = (w[6:0] == OPC_BRANCH);
        prev_load   = (w[6:0] == OPC_LOAD);
        load_rd     = w[11:7];
        ref_pc      = next_pc;
    endtask

    task automatic check_reset_state();
        if (rom_addr !== '0) report_mismatch(T_RESET, "rom_addr", 32'(rom_addr), 32'd0);
        if (ram_we !== 1'b0) report_mismatch(T_RESET, "ram_we", 32'(ram_we), 32'd0);
    endtask

    initial begin
        int   cyc;
        logic at_end;
        RESET_N = 1'b0;
        seed    = 850;
        for (int i = 0; i < 6; i++) errs[i] = 0;
        for (int i = 0; i < `NUM_REGS; i++) ref_reg[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i]     = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000; // varies with every address bit.
            ref_mem[i] = ram[i];
        end
        gen_program();
        rom[0] = store_word(12'd0, 5'd0); // reset must hold this store back.
        {tests_run, tests_failed, n_branch, n_store, n_load} = '0;
        {prev_branch, prev_load, load_rd, ref_pc} = '0;

        @(negedge CLK);
        check_reset_state(); // inside reset.
        @(posedge CLK);
        #1;
        rom[0]  = NOP;
        RESET_N = 1'b1;
        @(negedge CLK);
        check_reset_state();
        finish_test(T_RESET, "reset");

        cyc    = 0;
        at_end = 1'b0;
        while (!at_end && cyc < MAX_CYCLES) begin
            step_model(at_end);
            cyc++;
            if (!at_end) @(negedge CLK);
        end
        if (!at_end) begin
            $display("timeout: the program never reached its final self-branch in %0d cycles",
                     MAX_CYCLES);
            errs[T_FETCH]++;
        end
        finish_test(T_FETCH, "sequential fetch");
        finish_test(T_BRANCH, "branches");
        finish_test(T_STORE, "stores");
        finish_test(T_LOAD, "loads");

        for (int i = 0; i < MEM_WORDS; i++) begin
            if (ram[i] !== ref_mem[i]) report_mismatch(T_MEM, $sformatf("ram[%0d]", i),
                                                       ram[i], ref_mem[i]);
        end
        finish_test(T_MEM, "final memory");

        $display("summary: %0d tests, %0d passed, %0d failed (%0d beq, %0d sw, %0d lw)",
                 tests_run, tests_run - tests_failed, tests_failed, n_branch, n_store, n_load);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_decoder.sv
rv_imm_gen.sv
rv_regfile.sv
rv_core.sv
rv_core_checker.sv
rv_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the single-cycle RV32I core testbench.
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
